// File: Bender.yml
package:
  name: pipelined_shifter

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/shifter_pkg.sv
      - source/shift_stage_if.sv
      - source/shift_decode.sv
      - source/shift_coarse.sv
      - source/shift_fine.sv
      - source/pipelined_shifter.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_pipelined_shifter.sv

// File: list.f
+incdir+source
source/shifter_pkg.sv
source/shift_stage_if.sv
source/shift_decode.sv
source/shift_coarse.sv
source/shift_fine.sv
source/pipelined_shifter.sv
test/tb_pipelined_shifter.sv

// File: source/pipelined_shifter.sv
/*
 * Three-stage shifter for 24-bit words, fixed latency of 3 cycles.
 * No back-pressure, so result must be taken in the cycle out_valid is high.
 */
`timescale 1ns/1ps
`default_nettype none

`include "shifter_defines.svh"

module pipelined_shifter (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,       // One pulse per request
    input  logic [`SHIFT_WIDTH-1:0]  operand,
    input  logic [`SHIFT_AMT_W-1:0]  shift_amount,
    input  logic [2:0]               mode,           // shifter_pkg::shift_mode_e code
    output logic                     out_valid,
    output logic [`SHIFT_WIDTH-1:0]  result
);

    // --------------------
    // Stage links
    // --------------------
    shift_stage_if dec_to_coarse ();
    shift_stage_if coarse_to_fine ();

    // --------------------
    // Stages
    // --------------------

    // Request capture and mode decode
    shift_decode u_decode (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .operand      (operand),
        .shift_amount (shift_amount),
        .mode         (mode),
        .down         (dec_to_coarse.src)
    );

    // Steps of 8
    shift_coarse u_coarse (
        .clk    (clk),
        .arst_n (arst_n),
        .up     (dec_to_coarse.snk),
        .down   (coarse_to_fine.src)
    );

    // Last 0..7 bits, drives the outputs
    shift_fine u_fine (
        .clk       (clk),
        .arst_n    (arst_n),
        .up        (coarse_to_fine.snk),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

`default_nettype wire

// File: source/shift_coarse.sv
/*
 * Coarse stage. Moves the word by 0, 8 or 16 bits, or clears/fills for 24 and more.
 * Expects rotate amounts below 24, as the decode stage guarantees.
 */
`timescale 1ns/1ps
`default_nettype none

`include "shifter_defines.svh"

module shift_coarse (
    input  logic        clk,
    input  logic        arst_n,
    shift_stage_if.snk  up,
    shift_stage_if.src  down
);

    localparam int W = `SHIFT_WIDTH;

    // Low amount bits that stay for the fine stage
    localparam logic [`SHIFT_AMT_W-1:0] FINE_MASK = `SHIFT_AMT_W'(`SHIFT_STEP - 1);

    logic [`SHIFT_AMT_W-1:0]  coarse_amt;    // Multiple of the step, 0..24
    logic [W-1:0]             low_fill;      // Bits that enter from the right
    logic [W-1:0]             high_fill;     // Bits that enter from the left
    logic [2*W-1:0]           funnel_l;
    logic [2*W-1:0]           funnel_r;
    logic [W-1:0]             data_nxt;

    assign coarse_amt = up.amount & ~FINE_MASK;

    // --------------------
    // Funnel shifter
    // --------------------
    // The word sits next to its fill and the pair is shifted as one,
    // so zero fill, sign fill and wrap are all the same path
    always_comb begin
        low_fill  = (up.op == shifter_pkg::OP_ROL) ? up.data : '0;
        if (up.op == shifter_pkg::OP_ROR) begin
            high_fill = up.data;                        // Wrap
        end else if (up.op == shifter_pkg::OP_SAR) begin
            high_fill = {W{up.data[W-1]}};              // Sign
        end else begin
            high_fill = '0;
        end

        funnel_l = {up.data, low_fill} << coarse_amt;
        funnel_r = {high_fill, up.data} >> coarse_amt;

        case (up.op)
            shifter_pkg::OP_SHL,
            shifter_pkg::OP_ROL: data_nxt = funnel_l[2*W-1:W];  // Upper half after left move
            shifter_pkg::OP_SHR,
            shifter_pkg::OP_ROR,
            shifter_pkg::OP_SAR: data_nxt = funnel_r[W-1:0];    // Lower half after right move
            default:             data_nxt = up.data;
        endcase
        // Amount 24..31 gives coarse_amt 24: the whole word is fill,
        // i.e. zero for logical shifts and all sign bits for SAR
    end

    // --------------------
    // Stage register
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            down.valid  <= 1'b0;
            down.op     <= shifter_pkg::OP_SHL;
            down.amount <= '0;
            down.data   <= '0;
        end else begin
            down.valid <= up.valid;
            if (up.valid) begin
                down.op     <= up.op;
                down.amount <= up.amount & FINE_MASK;  // Upper bits consumed here
                down.data   <= data_nxt;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/shift_decode.sv
/*
 * Decode stage. Registers the request and maps the mode to an internal operation.
 * Rotate amounts of 24 to 31 are reduced by 24. Reserved modes become SHL by zero.
 */
`timescale 1ns/1ps
`default_nettype none

`include "shifter_defines.svh"

module shift_decode (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  logic [`SHIFT_WIDTH-1:0]  operand,
    input  logic [`SHIFT_AMT_W-1:0]  shift_amount,
    input  logic [2:0]               mode,
    shift_stage_if.src               down
);

    shifter_pkg::shift_mode_e    mode_e;
    shifter_pkg::shift_op_e      op_nxt;
    logic [`SHIFT_AMT_W-1:0]     amt_nxt;
    logic                        amt_wraps;     // Amount is past the word

    assign mode_e    = shifter_pkg::shift_mode_e'(mode);
    assign amt_wraps = (shift_amount >= `SHIFT_WIDTH);

    // --------------------
    // Mode decode
    // --------------------
    always_comb begin
        op_nxt  = shifter_pkg::OP_SHL;
        amt_nxt = shift_amount;
        case (mode_e)
            shifter_pkg::MODE_SHL: op_nxt = shifter_pkg::OP_SHL;
            shifter_pkg::MODE_SHR: op_nxt = shifter_pkg::OP_SHR;
            shifter_pkg::MODE_SAR: op_nxt = shifter_pkg::OP_SAR;
            shifter_pkg::MODE_ROL: begin
                op_nxt = shifter_pkg::OP_ROL;
                if (amt_wraps) begin
                    // Modulo 24; one subtract covers 24..31
                    amt_nxt = `SHIFT_AMT_W'(shift_amount - `SHIFT_WIDTH);
                end
            end
            shifter_pkg::MODE_ROR: begin
                op_nxt = shifter_pkg::OP_ROR;
                if (amt_wraps) begin
                    amt_nxt = `SHIFT_AMT_W'(shift_amount - `SHIFT_WIDTH);
                end
            end
            default: begin
                // Reserved code, operand passes unchanged
                op_nxt  = shifter_pkg::OP_SHL;
                amt_nxt = '0;
            end
        endcase
    end

    // --------------------
    // Stage register
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            down.valid  <= 1'b0;
            down.op     <= shifter_pkg::OP_SHL;
            down.amount <= '0;
            down.data   <= '0;
        end else begin
            down.valid <= in_valid;     // Single-cycle strobe, no hold
            if (in_valid) begin
                down.op     <= op_nxt;
                down.amount <= amt_nxt;
                down.data   <= operand;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/shift_fine.sv
/*
 * Fine stage. Moves the word by 0 to 7 bits and registers the pipeline result.
 * The SAR sign comes from the incoming word, whose top bit still holds the original sign.
 */
`timescale 1ns/1ps
`default_nettype none

`include "shifter_defines.svh"

module shift_fine (
    input  logic                     clk,
    input  logic                     arst_n,
    shift_stage_if.snk               up,
    output logic                     out_valid,
    output logic [`SHIFT_WIDTH-1:0]  result
);

    localparam int W      = `SHIFT_WIDTH;
    localparam int FINE_W = $clog2(`SHIFT_STEP);   // 3 bits for a step of 8

    logic [FINE_W-1:0]  fine_amt;
    logic [W-1:0]       rot_l;
    logic [W-1:0]       rot_r;
    logic [W-1:0]       data_nxt;

    assign fine_amt = up.amount[FINE_W-1:0];

    // Rotates within the word; for amount zero the far term is empty
    assign rot_l = (up.data << fine_amt) | (up.data >> (W - fine_amt));
    assign rot_r = (up.data >> fine_amt) | (up.data << (W - fine_amt));

    // --------------------
    // Final move
    // --------------------
    always_comb begin
        case (up.op)
            shifter_pkg::OP_SHL: data_nxt = up.data << fine_amt;
            shifter_pkg::OP_SHR: data_nxt = up.data >> fine_amt;
            shifter_pkg::OP_SAR: data_nxt = W'($signed(up.data) >>> fine_amt);
            shifter_pkg::OP_ROL: data_nxt = rot_l;
            shifter_pkg::OP_ROR: data_nxt = rot_r;
            default:             data_nxt = up.data;
        endcase
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= up.valid;      // Three edges after the request
            if (up.valid) begin
                result <= data_nxt;     // Holds until the next item
            end
        end
    end

endmodule

`default_nettype wire

// File: source/shift_stage_if.sv
/*
 * One pipeline item between two shifter stages.
 * The item is present only while valid is high. There is no ready, so the sink never stalls.
 */
`timescale 1ns/1ps
`default_nettype none

`include "shifter_defines.svh"

interface shift_stage_if;

    logic                        valid;   // Item present this cycle
    shifter_pkg::shift_op_e      op;      // Operation after decode
    logic [`SHIFT_AMT_W-1:0]     amount;  // Remaining amount
    logic [`SHIFT_WIDTH-1:0]     data;    // Partially shifted word

    // Producer side
    modport src (
        output valid,
        output op,
        output amount,
        output data
    );

    // Consumer side
    modport snk (
        input valid,
        input op,
        input amount,
        input data
    );

endinterface

`default_nettype wire

// File: source/shifter_defines.svh
/*
 * Width settings shared by the shifter pipeline.
 * The stages assume a 24-bit word, a 5-bit amount and a coarse step of 8.
 * The step must be a power of two.
 */
`ifndef SHIFTER_DEFINES_SVH
`define SHIFTER_DEFINES_SVH

// --------------------
// Datapath sizes
// --------------------

// Operand and result width
`define SHIFT_WIDTH 24

// Amount width, 0 to 31
`define SHIFT_AMT_W 5

// Coarse stage moves in steps of this size
// Amount bits 4..3 go to the coarse stage and bits 2..0 go to the fine stage
`define SHIFT_STEP 8

`endif

// File: source/shifter_pkg.sv
/*
 * Mode and operation encodings for the shifter.
 * External mode codes 5 to 7 are reserved and mean pass-through.
 */
`default_nettype none

package shifter_pkg;

    // --------------------
    // External mode codes
    // --------------------
    typedef enum logic [2:0] {
        MODE_SHL = 3'd0,    // Logical left
        MODE_SHR = 3'd1,    // Logical right
        MODE_ROL = 3'd2,    // Rotate left
        MODE_ROR = 3'd3,    // Rotate right
        MODE_SAR = 3'd4     // Arithmetic right
        // 5..7 reserved
    } shift_mode_e;

    // --------------------
    // Internal operations
    // --------------------
    // Set up by the decode stage
    // A reserved mode travels as OP_SHL with amount zero
    typedef enum logic [2:0] {
        OP_SHL = 3'd0,
        OP_SHR = 3'd1,
        OP_ROL = 3'd2,
        OP_ROR = 3'd3,
        OP_SAR = 3'd4
    } shift_op_e;

endpackage

`default_nettype wire

// File: test/tb_pipelined_shifter.sv
/*
 * Testbench for pipelined_shifter. Random requests come from a 32-bit Galois LFSR
 * and are checked against a bit-serial model. Assumes a fixed latency of 3 cycles.
 */
`timescale 1ns/1ps
`default_nettype none

`include "shifter_defines.svh"

module tb_pipelined_shifter;

    localparam int W       = `SHIFT_WIDTH;
    localparam int LATENCY = 3;

    logic                     clk;
    logic                     arst_n;
    logic                     in_valid;
    logic [W-1:0]             operand;
    logic [`SHIFT_AMT_W-1:0]  shift_amount;
    logic [2:0]               mode;
    logic                     out_valid;
    logic [W-1:0]             result;

    logic [31:0]              lfsr;         // Stimulus state
    int                       cycle;        // Rising edges seen so far
    int                       errors;
    int                       checks;
    int                       sent;
    int                       received;
    logic [W-1:0]             exp_q[$];     // Expected results with the oldest first
    int                       due_q[$];     // Cycle each result must show up in
    logic [`SHIFT_AMT_W-1:0]  edge_amt[4];
    logic [W-1:0]             edge_op[3];

    pipelined_shifter uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .operand      (operand),
        .shift_amount (shift_amount),
        .mode         (mode),
        .out_valid    (out_valid),
        .result       (result)
    );

    always #5 clk = ~clk;                   // 10 ns period

    always @(posedge clk) cycle <= cycle + 1;

    // --------------------
    // Stimulus helpers
    // --------------------

    // Galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Reference model that moves one bit position per step
    function automatic logic [W-1:0] expected_result(input logic [W-1:0] op,
                                                     input logic [`SHIFT_AMT_W-1:0] amt,
                                                     input logic [2:0] md);
        logic [W-1:0] r;
        int           n;
        r = op;
        n = amt;
        if (md == shifter_pkg::MODE_ROL || md == shifter_pkg::MODE_ROR) begin
            n = amt % W;                    // Rotate by 24 is the identity
        end
        if (md > 3'd4) begin
            n = 0;                          // Reserved codes pass through
        end
        for (int i = 0; i < n; i++) begin
            case (md)
                shifter_pkg::MODE_SHL: r = {r[W-2:0], 1'b0};
                shifter_pkg::MODE_SHR: r = {1'b0, r[W-1:1]};
                shifter_pkg::MODE_ROL: r = {r[W-2:0], r[W-1]};
                shifter_pkg::MODE_ROR: r = {r[0], r[W-1:1]};
                shifter_pkg::MODE_SAR: r = {r[W-1], r[W-1:1]};   // Sign stays in place
                default:               r = r;
            endcase
        end
        return r;                           // 24 or more steps leave only fill
    endfunction

    task automatic compare_values(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    // Drives one cycle; a valid request also goes to the model
    task automatic drive_request(input logic v, input logic [W-1:0] op,
                                 input logic [`SHIFT_AMT_W-1:0] amt, input logic [2:0] md);
        @(posedge clk);
        #1;
        in_valid     = v;
        operand      = op;
        shift_amount = amt;
        mode         = md;
        if (v) begin
            exp_q.push_back(expected_result(op, amt, md));
            due_q.push_back(cycle + LATENCY);   // Rises three edges after this one
            sent++;
        end
    endtask

    task automatic drive_random(input logic v);
        logic [31:0] op;
        logic [31:0] amt;
        logic [31:0] md;
        take_bits(W, op);
        take_bits(`SHIFT_AMT_W, amt);
        take_bits(3, md);                   // All eight codes
        drive_request(v, op[W-1:0], amt[`SHIFT_AMT_W-1:0], md[2:0]);
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Timeout: %0d results still missing after %0d cycles",
                     exp_q.size(), limit);
        end
    endtask

    // --------------------
    // Monitor
    // --------------------
    // Sampled mid-cycle away from the edge where outputs change
    always @(negedge clk) begin
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("out_valid was high at %0t ns with no request pending", $time);
            end else begin
                compare_values("result", result, exp_q.pop_front());
                compare_values("out_valid cycle", cycle, due_q.pop_front());
                received++;
            end
        end
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [31:0] gap;
        clk          = 1'b0;
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        operand      = '0;
        shift_amount = '0;
        mode         = '0;
        lfsr         = 32'haab022e3;
        cycle        = 0;
        errors       = 0;
        checks       = 0;
        sent         = 0;
        received     = 0;
        edge_amt[0]  = 5'd0;
        edge_amt[1]  = 5'd23;
        edge_amt[2]  = 5'd24;
        edge_amt[3]  = 5'd31;
        edge_op[0]   = 24'h800000;          // Sign bit only
        edge_op[1]   = 24'h000001;
        edge_op[2]   = 24'hFFFFFF;

        // Reset held for two edges
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
            #1;
            compare_values("out_valid", out_valid, 1'b0);
        end
        arst_n = 1'b1;

        for (int i = 0; i < 8; i++) begin
            drive_request(1'b0, '0, '0, '0);    // Idle while the monitor flags any pulse
        end

        for (int i = 0; i < 400; i++) begin
            drive_random(1'b1);             // Back-to-back burst
        end
        drive_request(1'b0, '0, '0, '0);
        wait_drain(10);

        foreach (edge_op[o]) begin
            foreach (edge_amt[a]) begin
                for (int m = 0; m < 5; m++) begin
                    drive_request(1'b1, edge_op[o], edge_amt[a], 3'(m));
                end
            end
        end
        drive_request(1'b0, '0, '0, '0);
        wait_drain(10);

        // Isolated requests with the latency checked per item
        for (int i = 0; i < 20; i++) begin
            drive_random(1'b1);
            drive_request(1'b0, '0, '0, '0);
            wait_drain(10);
        end

        for (int i = 0; i < 200; i++) begin
            take_bits(1, gap);
            drive_random(gap[0]);           // Idle cycles still carry random data
        end
        drive_request(1'b0, '0, '0, '0);
        wait_drain(20);

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results were left in the queue", exp_q.size());
        end
        compare_values("result count", received, sent);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
